//--- verilog/trigger_params.svh
// Trigger engine parameters

`ifndef TRIGGER_PARAMS_SVH
`define TRIGGER_PARAMS_SVH

// Number of sample streams feeding the trigger block
`define TRIG_N_CHANNELS 6

// Capture memory depth
// The fill wait ends when the fill counter reaches this value
`define TRIG_MEMORY_DEPTH 1023

// Number of words in the register bank
// The last word is the rearm strobe and status read-back
`define TRIG_N_REGS 8

`endif

//--- verilog/trigger_pkg.sv
// Trigger engine types

`default_nettype none

package trigger_pkg;

    // One sample word, either an IEEE-754 single or a signed integer
    typedef logic [31:0] sample_t;

    // Channel number and register index
    typedef logic [2:0] chan_idx_t;
    typedef logic [2:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Trigger position in the capture buffer and DMA base address
    typedef logic [15:0] trig_point_t;
    typedef logic [63:0] dma_addr_t;

    // One channel's sample together with its qualifiers
    typedef struct packed {
        sample_t data;
        logic is_float;
        logic valid;
    } sample_bus_t;

    typedef enum logic [1:0] {rising = 2'd0, falling = 2'd1, both = 2'd2} trig_mode_e;

    typedef enum logic [1:0] {normal = 2'd0, single = 2'd1, free_run = 2'd2} acq_mode_e;

    typedef enum logic [2:0] {
        wait_fill = 3'd0,
        run = 3'd1,
        stop = 3'd2,
        free_running = 3'd3
    } trig_state_e;

    // Decoded configuration, fanned out from the register bank
    typedef struct packed {
        trig_mode_e mode;
        sample_t level;
        chan_idx_t channel;
        trig_point_t trigger_point;
        acq_mode_e acq_mode;
        dma_addr_t dma_base_addr;
    } trig_config_t;

endpackage

`default_nettype wire

//--- verilog/trigger_registers.sv
// Trigger register bank

`timescale 1ns/1ns
`default_nettype none
`include "trigger_params.svh"

module trigger_registers (
    input wire logic clock,
    input wire logic arst_n,
    input wire logic reg_write,
    input trigger_pkg::reg_addr_t reg_addr,
    input trigger_pkg::reg_data_t reg_wdata,
    output trigger_pkg::reg_data_t reg_rdata,
    input trigger_pkg::trig_state_e state,
    output trigger_pkg::trig_config_t cfg,
    output logic rearm
);

    // Stored fields, each kept at its own width
    logic [1:0] mode_q;
    trigger_pkg::sample_t level_q;
    trigger_pkg::reg_data_t dma_lo_q;
    trigger_pkg::reg_data_t dma_hi_q;
    trigger_pkg::chan_idx_t channel_q;
    trigger_pkg::trig_point_t point_q;
    logic [1:0] acq_q;

    // Read-back words indexed by register number
    trigger_pkg::reg_data_t read_words [`TRIG_N_REGS];

    // Writes are masked to the field width so read-back shows what is used
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= '0;
            level_q <= '0;
            dma_lo_q <= '0;
            dma_hi_q <= '0;
            channel_q <= '0;
            point_q <= '0;
            acq_q <= '0;
            rearm <= 1'b0;
        end else begin
            // Rearm is a strobe and drops on the next cycle
            rearm <= 1'b0;
            if (reg_write) begin
                case (reg_addr)
                    3'd0: mode_q <= reg_wdata[1:0];
                    3'd1: level_q <= reg_wdata;
                    3'd2: dma_lo_q <= reg_wdata;
                    3'd3: dma_hi_q <= reg_wdata;
                    3'd4: channel_q <= reg_wdata[2:0];
                    3'd5: point_q <= reg_wdata[15:0];
                    3'd6: acq_q <= reg_wdata[1:0];
                    // Register 7 holds no data, a write only rearms the trigger
                    default: rearm <= 1'b1;
                endcase
            end
        end
    end

    // Assemble the configuration seen by the rest of the block
    always_comb begin
        cfg.mode = trigger_pkg::trig_mode_e'(mode_q);
        cfg.level = level_q;
        cfg.channel = channel_q;
        cfg.trigger_point = point_q;
        cfg.acq_mode = trigger_pkg::acq_mode_e'(acq_q);
        cfg.dma_base_addr = {dma_hi_q, dma_lo_q};
    end

    // Read mux, the last word reports the acquisition state
    always_comb begin
        read_words[0] = trigger_pkg::reg_data_t'(mode_q);
        read_words[1] = level_q;
        read_words[2] = dma_lo_q;
        read_words[3] = dma_hi_q;
        read_words[4] = trigger_pkg::reg_data_t'(channel_q);
        read_words[5] = trigger_pkg::reg_data_t'(point_q);
        read_words[6] = trigger_pkg::reg_data_t'(acq_q);
        read_words[`TRIG_N_REGS-1] = trigger_pkg::reg_data_t'(state);
        reg_rdata = read_words[reg_addr];
    end

    // The state machine expects a single-cycle rearm per register 7 write
    rearm_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
        rearm |=> !rearm);

endmodule

`default_nettype wire

//--- verilog/sample_selector.sv
// Trigger channel selector

`timescale 1ns/1ns
`default_nettype none
`include "trigger_params.svh"

module sample_selector (
    input wire logic clock,
    input wire logic arst_n,
    input trigger_pkg::sample_bus_t [`TRIG_N_CHANNELS-1:0] channels,
    input trigger_pkg::chan_idx_t channel,
    output trigger_pkg::sample_bus_t selected
);

    trigger_pkg::sample_bus_t chosen;
    trigger_pkg::sample_t data_q;
    logic is_float_q;
    logic valid_q;

    // Indices past the last channel read as an idle word
    // so a bad channel setting can never fire the trigger
    always_comb begin
        if (channel < `TRIG_N_CHANNELS) begin
            chosen = channels[channel];
        end else begin
            chosen = '0;
        end
    end

    // Sample payload, only meaningful together with valid
    always_ff @(posedge clock) begin
        data_q <= chosen.data;
        is_float_q <= chosen.is_float;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= chosen.valid;
        end
    end

    always_comb begin
        selected.data = data_q;
        selected.is_float = is_float_q;
        selected.valid = valid_q;
    end

endmodule

`default_nettype wire

//--- verilog/float_to_fixed.sv
// Float to integer converter

`timescale 1ns/1ns
`default_nettype none

module float_to_fixed (
    input wire logic clock,
    input wire logic arst_n,
    input trigger_pkg::sample_bus_t sample_in,
    output trigger_pkg::sample_t value,
    output logic value_valid
);

    // Biased exponents at the edges of the integer range
    localparam logic [7:0] EXP_ONE = 8'd127;
    localparam logic [7:0] EXP_UNIT_LSB = 8'd150;
    localparam logic [7:0] EXP_SATURATE = 8'd158;

    logic f_sign;
    logic [7:0] f_exp;
    logic [23:0] f_man;
    trigger_pkg::sample_t magnitude;
    trigger_pkg::sample_t float_result;

    always_comb begin
        f_sign = sample_in.data[31];
        f_exp = sample_in.data[30:23];
        // Restore the hidden leading one
        f_man = {1'b1, sample_in.data[22:0]};

        // At exponent 150 the mantissa LSB has weight one
        // Shifting right drops the fraction, which truncates toward zero
        if (f_exp >= EXP_UNIT_LSB) begin
            magnitude = trigger_pkg::sample_t'(f_man) << (f_exp - EXP_UNIT_LSB);
        end else begin
            magnitude = trigger_pkg::sample_t'(f_man) >> (EXP_UNIT_LSB - f_exp);
        end

        // Exponent 255 (infinity and NaN) also lands in the saturating branch
        if (f_exp >= EXP_SATURATE) begin
            float_result = f_sign ? 32'h8000_0000 : 32'h7fff_ffff;
        end else if (f_exp < EXP_ONE) begin
            // Magnitude below one, this also covers zero and denormals
            float_result = '0;
        end else begin
            float_result = f_sign ? -magnitude : magnitude;
        end
    end

    // One register serves both paths, so integer and float samples
    // leave the stage with the same latency
    always_ff @(posedge clock) begin
        if (sample_in.valid) begin
            value <= sample_in.is_float ? float_result : sample_in.data;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            value_valid <= 1'b0;
        end else begin
            value_valid <= sample_in.valid;
        end
    end

endmodule

`default_nettype wire

//--- verilog/trigger_fsm.sv
// Trigger acquisition state machine

`timescale 1ns/1ns
`default_nettype none
`include "trigger_params.svh"

module trigger_fsm (
    input wire logic clock,
    input wire logic arst_n,
    input trigger_pkg::sample_t value,
    input wire logic value_valid,
    input trigger_pkg::trig_config_t cfg,
    input wire logic rearm,
    output trigger_pkg::trig_state_e state,
    output logic trigger_out
);

    // Wide enough to hold the memory depth itself
    logic [$clog2(`TRIG_MEMORY_DEPTH+1)-1:0] fill_count;

    trigger_pkg::sample_t prev_value;
    logic have_prev;
    logic rising_edge;
    logic falling_edge;
    logic edge_hit;

    // Last valid sample, used as the other end of the crossing
    always_ff @(posedge clock) begin
        if (value_valid) begin
            prev_value <= value;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            have_prev <= 1'b0;
        end else if (value_valid) begin
            have_prev <= 1'b1;
        end
    end

    // Signed crossings of the level, equality counts on the arriving side
    always_comb begin
        rising_edge = ($signed(value) >= $signed(cfg.level)) &&
                      ($signed(prev_value) < $signed(cfg.level));
        falling_edge = ($signed(value) <= $signed(cfg.level)) &&
                       ($signed(prev_value) > $signed(cfg.level));
        case (cfg.mode)
            trigger_pkg::rising: edge_hit = rising_edge;
            trigger_pkg::falling: edge_hit = falling_edge;
            trigger_pkg::both: edge_hit = rising_edge || falling_edge;
            default: edge_hit = 1'b0;
        endcase
        edge_hit = edge_hit && have_prev;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= trigger_pkg::wait_fill;
            trigger_out <= 1'b0;
            fill_count <= '0;
        end else begin
            case (state)
                trigger_pkg::wait_fill: begin
                    // Arm only once the capture memory has been filled
                    trigger_out <= 1'b0;
                    if (fill_count == `TRIG_MEMORY_DEPTH) begin
                        state <= trigger_pkg::run;
                    end else begin
                        fill_count <= fill_count + 1'b1;
                    end
                end
                trigger_pkg::run: begin
                    if (cfg.acq_mode == trigger_pkg::free_run) begin
                        state <= trigger_pkg::free_running;
                        trigger_out <= 1'b1;
                    end else if (trigger_out && cfg.acq_mode == trigger_pkg::single) begin
                        // Single shot, park after the first trigger
                        state <= trigger_pkg::stop;
                        trigger_out <= 1'b0;
                    end else begin
                        trigger_out <= value_valid && edge_hit;
                    end
                end
                trigger_pkg::stop: begin
                    trigger_out <= 1'b0;
                    if (cfg.acq_mode == trigger_pkg::free_run) begin
                        state <= trigger_pkg::free_running;
                        trigger_out <= 1'b1;
                    end else if (rearm || cfg.acq_mode != trigger_pkg::single) begin
                        state <= trigger_pkg::run;
                    end
                end
                trigger_pkg::free_running: begin
                    // Trigger held high as long as free-run is selected
                    if (cfg.acq_mode != trigger_pkg::free_run) begin
                        state <= trigger_pkg::run;
                        trigger_out <= 1'b0;
                    end else begin
                        trigger_out <= 1'b1;
                    end
                end
                default: begin
                    state <= trigger_pkg::wait_fill;
                    trigger_out <= 1'b0;
                end
            endcase
        end
    end

    // No trigger may leave the block before arming or while parked
    trigger_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        (state inside {trigger_pkg::wait_fill, trigger_pkg::stop}) |-> !trigger_out);

endmodule

`default_nettype wire

//--- verilog/trigger_engine.sv
// Trigger engine top level

`timescale 1ns/1ns
`default_nettype none
`include "trigger_params.svh"

module trigger_engine (
    input wire logic clock,
    input wire logic arst_n,
    input trigger_pkg::sample_bus_t [`TRIG_N_CHANNELS-1:0] channels,
    input wire logic reg_write,
    input trigger_pkg::reg_addr_t reg_addr,
    input trigger_pkg::reg_data_t reg_wdata,
    output trigger_pkg::reg_data_t reg_rdata,
    output logic trigger_out,
    output trigger_pkg::trig_point_t trigger_point,
    output trigger_pkg::dma_addr_t dma_base_addr
);

    trigger_pkg::trig_config_t cfg;
    trigger_pkg::trig_state_e state;
    logic rearm;
    trigger_pkg::sample_bus_t selected;
    trigger_pkg::sample_t value;
    logic value_valid;

    trigger_registers registers_inst (
        .clock(clock),
        .arst_n(arst_n),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .state(state),
        .cfg(cfg),
        .rearm(rearm)
    );

    // Selector, converter and state machine form the three-edge trigger path
    sample_selector selector_inst (
        .clock(clock),
        .arst_n(arst_n),
        .channels(channels),
        .channel(cfg.channel),
        .selected(selected)
    );

    float_to_fixed converter_inst (
        .clock(clock),
        .arst_n(arst_n),
        .sample_in(selected),
        .value(value),
        .value_valid(value_valid)
    );

    trigger_fsm fsm_inst (
        .clock(clock),
        .arst_n(arst_n),
        .value(value),
        .value_valid(value_valid),
        .cfg(cfg),
        .rearm(rearm),
        .state(state),
        .trigger_out(trigger_out)
    );

    // Buffer description for the capture memory and DMA engine
    assign trigger_point = cfg.trigger_point;
    assign dma_base_addr = cfg.dma_base_addr;

endmodule

`default_nettype wire

//--- tb/trigger_engine_tb.sv
// Trigger engine testbench

`timescale 1ns/1ns
`default_nettype none
`include "trigger_params.svh"

module trigger_engine_tb;

    localparam int CLOCK_PERIOD = 4;
    // Reset, fill wait and the summed length of all tests, in cycles
    localparam int FILL_CYCLES = `TRIG_MEMORY_DEPTH + 1 + 10;
    localparam int TEST_CYCLES = 700;
    localparam int WATCHDOG_NS = 2 * (FILL_CYCLES + TEST_CYCLES) * CLOCK_PERIOD;

    logic clock;
    logic arst_n;
    trigger_pkg::sample_bus_t [`TRIG_N_CHANNELS-1:0] channels;
    logic reg_write;
    trigger_pkg::reg_addr_t reg_addr;
    trigger_pkg::reg_data_t reg_wdata;
    trigger_pkg::reg_data_t reg_rdata;
    logic trigger_out;
    trigger_pkg::trig_point_t trigger_point;
    trigger_pkg::dma_addr_t dma_base_addr;

    // Reference model state, only changed on the falling edge
    trigger_pkg::trig_mode_e model_mode = trigger_pkg::rising;
    trigger_pkg::sample_t model_level = '0;
    trigger_pkg::chan_idx_t model_chan = '0;
    logic model_run = 1'b0;
    trigger_pkg::sample_t model_prev = '0;
    logic model_have_prev = 1'b0;
    // Each entry holds {check enable, expected trigger}
    logic [1:0] expect_q[$];
    logic [31:0] lfsr_state = 32'd80766;
    int n_pass = 0;
    int n_fail = 0;

    trigger_engine trigger_engine_inst (
        .clock(clock),
        .arst_n(arst_n),
        .channels(channels),
        .reg_write(reg_write),
        .reg_addr(reg_addr),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .trigger_out(trigger_out),
        .trigger_point(trigger_point),
        .dma_base_addr(dma_base_addr)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // Sign-extended random value of n bits
    function automatic trigger_pkg::sample_t rand_signed(input int n);
        return trigger_pkg::sample_t'($signed(rand_bits(n) << (32 - n)) >>> (32 - n));
    endfunction

    function automatic trigger_pkg::sample_bus_t int_sample(input trigger_pkg::sample_t v);
        trigger_pkg::sample_bus_t w;
        w.data = v;
        w.is_float = 1'b0;
        w.valid = 1'b1;
        return w;
    endfunction

    // Width of each stored field as seen on read-back
    function automatic trigger_pkg::reg_data_t field_mask(input int a);
        case (a)
            0, 6: return 32'h0000_0003;
            4: return 32'h0000_0007;
            5: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

    // Truncation toward zero, saturation at exponent 31 and for infinity or NaN
    function automatic trigger_pkg::sample_t ref_float_to_fixed(input trigger_pkg::sample_t f);
        int exponent;
        logic [63:0] mag;
        exponent = int'(f[30:23]) - 127;
        mag = {40'd0, 1'b1, f[22:0]};
        if (f[30:23] == 8'hff || exponent >= 31) begin
            return f[31] ? 32'h8000_0000 : 32'h7fff_ffff;
        end
        if (exponent < 0) begin
            return '0;
        end
        if (exponent >= 23) begin
            mag = mag << (exponent - 23);
        end else begin
            mag = mag >> (23 - exponent);
        end
        return f[31] ? -mag[31:0] : mag[31:0];
    endfunction

    function automatic logic ref_trigger(input trigger_pkg::sample_t prev,
                                         input trigger_pkg::sample_t cur,
                                         input trigger_pkg::sample_t level,
                                         input trigger_pkg::trig_mode_e mode);
        logic rise;
        logic fall;
        rise = ($signed(cur) >= $signed(level)) && ($signed(prev) < $signed(level));
        fall = ($signed(cur) <= $signed(level)) && ($signed(prev) > $signed(level));
        case (mode)
            trigger_pkg::rising: return rise;
            trigger_pkg::falling: return fall;
            trigger_pkg::both: return rise || fall;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_data(input trigger_pkg::reg_data_t actual,
                              input trigger_pkg::reg_data_t expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_trigger(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, actual, expected);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_state(input trigger_pkg::trig_state_e actual,
                               input trigger_pkg::trig_state_e expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %0d, expected %s", $time, what, actual,
                     expected.name());
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    // The model takes the inputs at each rising edge, when they are stable,
    // and trigger_out is read before that edge updates it, three edges later
    always @(posedge clock) begin : model_compare
        logic [1:0] entry;
        trigger_pkg::sample_bus_t word;
        trigger_pkg::sample_t cur;
        logic expected;
        if (expect_q.size() == 3) begin
            entry = expect_q.pop_front();
            if (entry[1]) begin
                check_trigger(trigger_out, entry[0], "trigger_out against the model");
            end
        end
        word = (model_chan < `TRIG_N_CHANNELS) ? channels[model_chan] : '0;
        expected = 1'b0;
        if (word.valid) begin
            cur = word.is_float ? ref_float_to_fixed(word.data) : word.data;
            expected = model_have_prev && ref_trigger(model_prev, cur, model_level, model_mode);
            model_prev = cur;
            model_have_prev = 1'b1;
        end
        expect_q.push_back({model_run, expected});
    end

    // Selected channel gets the word, the others carry unrelated traffic
    task automatic drive_sample(input trigger_pkg::sample_bus_t word);
        @(negedge clock);
        for (int ch = 0; ch < `TRIG_N_CHANNELS; ch++) begin
            if (ch == model_chan) begin
                channels[ch] = word;
            end else begin
                channels[ch].data = rand_bits(32);
                channels[ch].is_float = rand_bits(1) != 0;
                channels[ch].valid = rand_bits(1) != 0;
            end
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clock);
            channels = '0;
        end
    endtask

    task automatic write_reg(input trigger_pkg::reg_addr_t a, input trigger_pkg::reg_data_t d);
        @(negedge clock);
        reg_write = 1'b1;
        reg_addr = a;
        reg_wdata = d;
        @(negedge clock);
        reg_write = 1'b0;
    endtask

    task automatic read_reg(input trigger_pkg::reg_addr_t a, output trigger_pkg::reg_data_t d);
        @(negedge clock);
        reg_addr = a;
        #1;
        d = reg_rdata;
    endtask

    task automatic read_state(output trigger_pkg::trig_state_e st);
        trigger_pkg::reg_data_t d;
        read_reg(3'd7, d);
        st = trigger_pkg::trig_state_e'(d[2:0]);
    endtask

    task automatic wait_state(input trigger_pkg::trig_state_e expected, input int limit);
        trigger_pkg::trig_state_e st;
        int count;
        count = 0;
        read_state(st);
        while (st != expected && count < limit) begin
            read_state(st);
            count++;
        end
        check_state(st, expected, "status while waiting for a state change");
    endtask

    task automatic wait_trigger(input int limit);
        int count;
        count = 0;
        idle(1);
        while (!trigger_out && count < limit) begin
            idle(1);
            count++;
        end
        if (!trigger_out) begin
            $display("Error at %0t: no trigger arrived within %0d cycles", $time, limit);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    // Channels are idle while the configuration changes, so no sample in flight
    // sees a level or mode other than the one the model used
    task automatic configure(input trigger_pkg::trig_mode_e mode, input trigger_pkg::sample_t level,
                             input trigger_pkg::chan_idx_t chan, input trigger_pkg::acq_mode_e acq);
        idle(3);
        write_reg(3'd0, trigger_pkg::reg_data_t'(mode));
        write_reg(3'd1, level);
        write_reg(3'd4, trigger_pkg::reg_data_t'(chan));
        write_reg(3'd6, trigger_pkg::reg_data_t'(acq));
        model_mode = mode;
        model_level = level;
        model_chan = chan;
    endtask

    task automatic register_test();
        trigger_pkg::reg_data_t written [7];
        trigger_pkg::reg_data_t rd;
        for (int a = 0; a < 7; a++) begin
            written[a] = rand_bits(32);
            write_reg(trigger_pkg::reg_addr_t'(a), written[a]);
        end
        for (int a = 0; a < 7; a++) begin
            read_reg(trigger_pkg::reg_addr_t'(a), rd);
            check_data(rd, written[a] & field_mask(a), $sformatf("register %0d read-back", a));
        end
        check_data(trigger_pkg::reg_data_t'(trigger_point), written[5] & 32'h0000_ffff,
                   "trigger_point output");
        check_data(dma_base_addr[31:0], written[2], "dma_base_addr low word");
        check_data(dma_base_addr[63:32], written[3], "dma_base_addr high word");
    endtask

    // Crossings during the fill must be ignored until the block arms
    task automatic fill_test();
        trigger_pkg::trig_state_e st;
        configure(trigger_pkg::rising, 32'd100, 3'd2, trigger_pkg::normal);
        for (int i = 0; i < 40; i++) begin
            drive_sample(int_sample((i % 2) ? 32'd500 : trigger_pkg::sample_t'(-50)));
            check_trigger(trigger_out, 1'b0, "trigger_out during fill");
        end
        read_state(st);
        check_state(st, trigger_pkg::wait_fill, "status during fill");
        idle(1);
        wait_state(trigger_pkg::run, FILL_CYCLES);
    endtask

    task automatic edge_test();
        trigger_pkg::chan_idx_t chan;
        trigger_pkg::sample_bus_t word;
        chan = trigger_pkg::chan_idx_t'(rand_bits(8) % `TRIG_N_CHANNELS);
        model_run = 1'b1;
        for (int m = 0; m < 3; m++) begin
            configure(trigger_pkg::trig_mode_e'(m), rand_signed(8), chan, trigger_pkg::normal);
            for (int i = 0; i < 60; i++) begin
                word = int_sample(rand_signed(9));
                word.valid = rand_bits(3) != 0;
                drive_sample(word);
            end
            idle(4);
        end
    endtask

    // Exponents 120 to 160 reach below one and past saturation
    task automatic float_test();
        trigger_pkg::sample_bus_t word;
        logic [7:0] f_exp;
        logic [22:0] man;
        logic s;
        configure(trigger_pkg::both, rand_signed(12), model_chan, trigger_pkg::normal);
        for (int i = 0; i < 100; i++) begin
            f_exp = 8'(120 + rand_bits(6) % 41);
            if (rand_bits(4) == 0) begin
                f_exp = 8'hff;
            end
            man = 23'(rand_bits(23));
            s = rand_bits(1) != 0;
            word.data = {s, f_exp, man};
            word.is_float = 1'b1;
            word.valid = 1'b1;
            drive_sample(word);
        end
        idle(4);
        model_run = 1'b0;
    endtask

    task automatic single_shot_test();
        trigger_pkg::trig_state_e st;
        configure(trigger_pkg::rising, '0, model_chan, trigger_pkg::single);
        drive_sample(int_sample(trigger_pkg::sample_t'(-10)));
        drive_sample(int_sample(32'd10));
        wait_trigger(8);
        idle(1);
        check_trigger(trigger_out, 1'b0, "trigger_out after the single shot");
        read_state(st);
        check_state(st, trigger_pkg::stop, "status after the single shot");
        // Later crossings are parked until the rearm
        for (int i = 0; i < 10; i++) begin
            drive_sample(int_sample((i % 2) ? 32'd10 : trigger_pkg::sample_t'(-10)));
            check_trigger(trigger_out, 1'b0, "trigger_out in stop");
        end
        idle(4);
        write_reg(3'd7, '0);
        read_state(st);
        check_state(st, trigger_pkg::run, "status after rearm");
        drive_sample(int_sample(trigger_pkg::sample_t'(-10)));
        drive_sample(int_sample(32'd10));
        wait_trigger(8);
        idle(2);
        write_reg(3'd6, trigger_pkg::reg_data_t'(trigger_pkg::normal));
    endtask

    task automatic free_run_test();
        trigger_pkg::trig_state_e st;
        write_reg(3'd6, trigger_pkg::reg_data_t'(trigger_pkg::free_run));
        wait_state(trigger_pkg::free_running, 4);
        for (int i = 0; i < 10; i++) begin
            drive_sample(int_sample(rand_signed(9)));
            check_trigger(trigger_out, 1'b1, "trigger_out in free-run");
        end
        idle(3);
        write_reg(3'd6, trigger_pkg::reg_data_t'(trigger_pkg::normal));
        read_state(st);
        check_state(st, trigger_pkg::run, "status after leaving free-run");
        check_trigger(trigger_out, 1'b0, "trigger_out after leaving free-run");
        // Normal edge detection resumes under the model
        model_run = 1'b1;
        for (int i = 0; i < 40; i++) begin
            drive_sample(int_sample(rand_signed(9)));
        end
        idle(4);
        model_run = 1'b0;
    endtask

    task automatic report_test(input string name, input int fails_before);
        if (n_fail == fails_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, n_fail - fails_before);
        end
    endtask

    initial begin
        int fails_before;
        clock = 1'b0;
        arst_n = 1'b0;
        channels = '0;
        reg_write = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        repeat (10) @(negedge clock);
        arst_n = 1'b1;
        fails_before = n_fail;
        register_test();
        report_test("register read-back", fails_before);
        fails_before = n_fail;
        fill_test();
        report_test("fill wait", fails_before);
        fails_before = n_fail;
        edge_test();
        report_test("integer edges", fails_before);
        fails_before = n_fail;
        float_test();
        report_test("float edges", fails_before);
        fails_before = n_fail;
        single_shot_test();
        report_test("single acquisition", fails_before);
        fails_before = n_fail;
        free_run_test();
        report_test("free-run acquisition", fails_before);
        $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Stops a hung run, twice the reset, fill and test time
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+verilog
verilog/trigger_pkg.sv
verilog/trigger_registers.sv
verilog/sample_selector.sv
verilog/float_to_fixed.sv
verilog/trigger_fsm.sv
verilog/trigger_engine.sv
tb/trigger_engine_tb.sv
